/* verilog.f */
src/qctrl_pkg.sv
src/proc_ctrl.sv
src/pulse_regs.sv
src/elem_dispatch.sv
src/proc_core.sv
tb/proc_core_tb.sv

/* Bender.yml */
package:
  name: qctrl_core

sources:
  - src/qctrl_pkg.sv
  - src/proc_ctrl.sv
  - src/pulse_regs.sv
  - src/elem_dispatch.sv
  - src/proc_core.sv
  - target: test
    files:
      - tb/proc_core_tb.sv

/* tb/proc_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module proc_core_tb;
	import qctrl_pkg::*;

	localparam int cycle_limit = 3000; // the tests take well under 900 cycles.

	logic clk;
	logic arst_n = 1'b0;
	logic [127:0] cmd_mem [0:255];
	logic [127:0] cmd_pipe [0:2] = '{default: '0}; // three-cycle read latency.
	logic [31:0] fb_table [0:255];
	logic fproc_ack = 1'b0;
	logic [31:0] fproc_result = '0;
	logic [2:0] force_busy = '0;
	logic [2:0] model_busy = '0;
	logic [2:0][2:0] busy_cnt = '0;
	logic [2:0] ack_delay = 3'd2;
	logic [3:0] hold_cnt = '0;
	logic req_q = 1'b0;
	logic [15:0] last_addr = '0;
	logic [69:0] pulses[$];
	logic [69:0] exp_pulses[$];
	logic [15:0] addrs[$];
	logic [15:0] exp_addrs[$];
	integer seed = 32'h2b98;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int handshakes = 0;

	wire [15:0] cmd_read_addr;
	wire fproc_req;
	wire [7:0] fproc_id;
	wire qdrv_stb, rdrv_stb, rdlo_stb;
	wire [9:0] qdrv_env_start, qdrv_env_length;
	wire [11:0] rdrv_env_start, rdrv_env_length, rdlo_env_start, rdlo_env_length;
	wire [15:0] qdrv_amp, rdrv_amp, rdlo_amp;
	wire [8:0] qdrv_freq, rdrv_freq, rdlo_freq;
	wire [16:0] qdrv_phase, rdrv_phase, rdlo_phase;
	wire [1:0] qdrv_mode, rdrv_mode, rdlo_mode;
	wire idle, done;
	wire [127:0] command = cmd_pipe[2];
	wire [2:0] stb_vec = {rdlo_stb, rdrv_stb, qdrv_stb};
	wire qdrv_busy = force_busy[0] | model_busy[0];
	wire rdrv_busy = force_busy[1] | model_busy[1];
	wire rdlo_busy = force_busy[2] | model_busy[2];

	proc_core #(.cmd_addr_width(16), .cmd_mem_read_latency(3)) uut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	// command memory, data arrives three edges after the address.
	always @(posedge clk) begin
		cmd_pipe[0] <= cmd_mem[cmd_read_addr[7:0]];
		cmd_pipe[1] <= cmd_pipe[0];
		cmd_pipe[2] <= cmd_pipe[1];
	end

	// elements stay busy for a few cycles after each strobe.
	always @(posedge clk) begin
		for (int i = 0; i < 3; i++) begin
			if (stb_vec[i]) begin
				busy_cnt[i] <= 3'd4;
			end else if (busy_cnt[i] != 0) begin
				busy_cnt[i] <= busy_cnt[i] - 1'b1;
			end
			model_busy[i] <= stb_vec[i] || (busy_cnt[i] > 1);
		end
	end

	// feedback processor with random ack delay and release.
	always @(posedge clk) begin
		if (!arst_n) begin
			fproc_ack <= 1'b0;
		end else begin
			assert (!(req_q && !fproc_req && !fproc_ack)) else begin
				errors++;
				$display("handshake: fproc_req dropped before fproc_ack was raised");
			end
			assert (!(!req_q && fproc_req && fproc_ack)) else begin
				errors++;
				$display("handshake: fproc_req raised while fproc_ack was still high");
			end
			if (fproc_req && !fproc_ack) begin
				if (ack_delay == 0) begin
					fproc_ack <= 1'b1;
					fproc_result <= fb_table[fproc_id];
					handshakes++;
					ack_delay <= 3'({$random(seed)} % 5);
					hold_cnt <= 4'(7 + {$random(seed)} % 4);
				end else begin
					ack_delay <= ack_delay - 1'b1;
				end
			end else if (!fproc_req && fproc_ack) begin
				// ack outlasts the next fetch, so a back-to-back request has to wait.
				if (hold_cnt == 0) begin
					fproc_ack <= 1'b0;
				end else begin
					hold_cnt <= hold_cnt - 1'b1;
				end
			end
		end
		req_q <= fproc_req;
	end

	// records element strobes and address changes.
	always @(posedge clk) begin
		if (arst_n) begin
			if (qdrv_stb) begin
				pulses.push_back({elem_qdrv, 2'd0, qdrv_env_start, 2'd0, qdrv_env_length,
					qdrv_amp, qdrv_freq, qdrv_phase, qdrv_mode});
			end
			if (rdrv_stb) begin
				pulses.push_back({elem_rdrv, rdrv_env_start, rdrv_env_length,
					rdrv_amp, rdrv_freq, rdrv_phase, rdrv_mode});
			end
			if (rdlo_stb) begin
				pulses.push_back({elem_rdlo, rdlo_env_start, rdlo_env_length,
					rdlo_amp, rdlo_freq, rdlo_phase, rdlo_mode});
			end
			if (cmd_read_addr != last_addr) begin
				addrs.push_back(cmd_read_addr);
				last_addr = cmd_read_addr;
			end
		end
	end

	function automatic logic [127:0] pulse_cmd(input opcode_t op, input logic [3:0] cfg,
		input logic [15:0] amp, input logic [8:0] freq, input logic [16:0] phase,
		input logic [23:0] env);
		logic [127:0] c;
		c = '0;
		c[127:124] = op;
		c[123:120] = cfg;
		c[119:104] = amp;
		c[103:95] = freq;
		c[94:78] = phase;
		c[77:54] = env;
		return c;
	endfunction

	// trigger fields other than cfg must be ignored.
	function automatic logic [127:0] trig_cmd(input logic [3:0] cfg);
		return pulse_cmd(op_pulse_trig, cfg, 16'hdead, 9'h155, 17'h0bead, 24'hc0ffee);
	endfunction

	function automatic logic [127:0] ctrl_cmd(input opcode_t op, input logic [15:0] target,
		input logic [7:0] id, input logic [31:0] imm);
		logic [127:0] c;
		c = '0;
		c[127:124] = op;
		c[63:48] = target;
		c[47:40] = id;
		c[31:0] = imm;
		return c;
	endfunction

	// expected channel record, envelope sliced per element.
	function automatic logic [69:0] pulse_rec(input elem_t elem, input logic [23:0] env,
		input logic [15:0] amp, input logic [8:0] freq, input logic [16:0] phase,
		input logic [1:0] mode);
		logic [11:0] start;
		logic [11:0] len;
		if (elem == elem_qdrv) begin
			start = {2'b0, env[9:0]};
			len = {2'b0, env[21:12]};
		end else begin
			start = env[11:0];
			len = env[23:12];
		end
		return {elem, start, len, amp, freq, phase, mode};
	endfunction

	task automatic check_val(input string test, input logic [127:0] exp,
		input logic [127:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("ERROR %s expected %0h actual %0h", test, exp, act);
		end
	endtask

	task automatic clear_mem();
		for (int a = 0; a < 256; a++) begin
			cmd_mem[a] = ctrl_cmd(op_nop, 16'(a), 8'(a), 32'(a));
			fb_table[a] = {4{8'(a)}};
		end
		exp_pulses.delete();
	endtask

	task automatic apply_reset(input string test);
		@(posedge clk);
		arst_n <= 1'b0;
		repeat (5) @(posedge clk);
		pulses.delete();
		addrs.delete();
		addrs.push_back(16'd0);
		last_addr = '0;
		check_val({test, " reset"}, '0,
			{qdrv_stb, rdrv_stb, rdlo_stb, fproc_req, done, cmd_read_addr});
		arst_n <= 1'b1;
	endtask

	// walks the program by the branch rules to get the address order.
	task automatic predict_addrs();
		logic [15:0] ip;
		logic [127:0] c;
		logic stop;
		ip = '0;
		stop = 1'b0;
		exp_addrs.delete();
		for (int n = 0; n < 64 && !stop; n++) begin
			if (exp_addrs.size() == 0 || exp_addrs[$] != ip) begin
				exp_addrs.push_back(ip);
			end
			c = cmd_mem[ip[7:0]];
			case (c[127:124])
				op_done: stop = 1'b1;
				op_jump: ip = c[63:48];
				op_jump_fproc: ip = (fb_table[c[47:40]] == c[31:0]) ? c[63:48] : ip + 1'b1;
				default: ip = ip + 1'b1;
			endcase
		end
	endtask

	task automatic run_program(input string test);
		predict_addrs();
		apply_reset(test);
		while (done !== 1'b1) @(posedge clk);
		repeat (4) @(posedge clk);
		check_val({test, " addr count"}, exp_addrs.size(), addrs.size());
		for (int i = 0; i < exp_addrs.size() && i < addrs.size(); i++) begin
			check_val({test, " addr"}, exp_addrs[i], addrs[i]);
		end
		check_val({test, " pulse count"}, exp_pulses.size(), pulses.size());
		for (int i = 0; i < exp_pulses.size() && i < pulses.size(); i++) begin
			check_val({test, " pulse"}, exp_pulses[i], pulses[i]);
		end
	endtask

	task automatic test_reset();
		clear_mem();
		cmd_mem[0] = ctrl_cmd(op_jump, 16'd7, 8'd0, 32'd0);
		cmd_mem[7] = ctrl_cmd(op_done, 16'd0, 8'd0, 32'd0);
		run_program("reset run");
		apply_reset("reset"); // done and a nonzero address are cleared.
	endtask

	task automatic test_element_pulses();
		clear_mem();
		cmd_mem[0] = pulse_cmd(op_pulse_write, 4'h0, 16'h1234, 9'h0a5, 17'h15a5a, 24'habcdef);
		cmd_mem[1] = trig_cmd(4'h4);
		cmd_mem[2] = pulse_cmd(op_pulse_write, 4'h0, 16'h0f0f, 9'h133, 17'h0c3c3, 24'h123456);
		cmd_mem[3] = trig_cmd(4'h9);
		cmd_mem[4] = pulse_cmd(op_pulse_write, 4'h0, 16'h8001, 9'h07e, 17'h1ffff, 24'hfedcba);
		cmd_mem[5] = trig_cmd(4'he);
		cmd_mem[6] = trig_cmd(4'h3); // select 3 reaches no element.
		cmd_mem[7] = ctrl_cmd(op_done, 16'd0, 8'd0, 32'd0);
		exp_pulses.push_back(pulse_rec(elem_qdrv, 24'habcdef, 16'h1234, 9'h0a5, 17'h15a5a, 2'd1));
		exp_pulses.push_back(pulse_rec(elem_rdrv, 24'h123456, 16'h0f0f, 9'h133, 17'h0c3c3, 2'd2));
		exp_pulses.push_back(pulse_rec(elem_rdlo, 24'hfedcba, 16'h8001, 9'h07e, 17'h1ffff, 2'd3));
		run_program("element pulses");
	endtask

	task automatic test_stored_fields();
		clear_mem();
		cmd_mem[0] = pulse_cmd(op_pulse_write, 4'h3, 16'hbeef, 9'h1ff, 17'h00001, 24'h5af00d);
		cmd_mem[1] = trig_cmd(4'h0);
		cmd_mem[2] = trig_cmd(4'h5);
		cmd_mem[3] = trig_cmd(4'ha);
		cmd_mem[4] = ctrl_cmd(op_done, 16'd0, 8'd0, 32'd0);
		exp_pulses.push_back(pulse_rec(elem_qdrv, 24'h5af00d, 16'hbeef, 9'h1ff, 17'h00001, 2'd0));
		exp_pulses.push_back(pulse_rec(elem_rdrv, 24'h5af00d, 16'hbeef, 9'h1ff, 17'h00001, 2'd1));
		exp_pulses.push_back(pulse_rec(elem_rdlo, 24'h5af00d, 16'hbeef, 9'h1ff, 17'h00001, 2'd2));
		run_program("stored fields");
	endtask

	task automatic test_jumps();
		clear_mem();
		cmd_mem[0] = ctrl_cmd(op_jump, 16'd4, 8'd0, 32'd0);
		cmd_mem[1] = ctrl_cmd(op_done, 16'd0, 8'd0, 32'd0);
		cmd_mem[4] = ctrl_cmd(op_nop, 16'd9, 8'd0, 32'd0);
		cmd_mem[5] = ctrl_cmd(op_jump, 16'd2, 8'd0, 32'd0);
		cmd_mem[2] = pulse_cmd(op_pulse_write, 4'h0, 16'h1111, 9'h022, 17'h00333, 24'h444444);
		cmd_mem[3] = ctrl_cmd(op_done, 16'd0, 8'd0, 32'd0);
		run_program("jumps");
		repeat (8) begin
			@(posedge clk);
			check_val("jumps done hold", 1'b1, done);
		end
		check_val("jumps final addr", 16'd3, cmd_read_addr);
	endtask

	task automatic test_feedback();
		clear_mem();
		cmd_mem[0] = ctrl_cmd(op_jump_fproc, 16'd5, 8'd1, 32'h01010101); // taken.
		cmd_mem[5] = ctrl_cmd(op_jump_fproc, 16'd9, 8'd2, 32'h00000000);
		cmd_mem[6] = ctrl_cmd(op_jump_fproc, 16'd12, 8'd3, 32'h03030303);
		cmd_mem[12] = ctrl_cmd(op_jump_fproc, 16'd2, 8'd4, 32'h00000001);
		cmd_mem[13] = ctrl_cmd(op_done, 16'd0, 8'd0, 32'd0);
		handshakes = 0;
		run_program("feedback");
		check_val("feedback handshakes", 4, handshakes);
	endtask

	task automatic test_idle();
		logic [23:0] pats;
		logic [2:0] pat;
		logic [2:0] prev;
		pats = {3'd1, 3'd3, 3'd7, 3'd6, 3'd4, 3'd0, 3'd5, 3'd2};
		prev = 3'd0;
		repeat (8) @(posedge clk); // element models drain first.
		for (int i = 0; i < 8; i++) begin
			pat = pats[3*i +: 3];
			@(posedge clk);
			force_busy <= pat;
			@(posedge clk);
			check_val("idle late", !(|prev), idle);
			@(posedge clk);
			check_val("idle", !(|pat), idle);
			prev = pat;
		end
		@(posedge clk);
		force_busy <= '0;
	endtask

	initial begin
		test_reset();
		test_element_pulses();
		test_stored_fields();
		test_jumps();
		test_feedback();
		test_idle();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* src/proc_core.sv */
`timescale 1ns/10ps
`default_nettype none

module proc_core #(
	parameter int cmd_addr_width = 16,
	parameter int cmd_mem_read_latency = 3
) (
	input wire clk,
	input wire arst_n,
	input wire [qctrl_pkg::cmd_width-1:0] command,
	output wire [cmd_addr_width-1:0] cmd_read_addr,
	output wire fproc_req,
	output wire [qctrl_pkg::fproc_id_width-1:0] fproc_id,
	input wire fproc_ack,
	input wire [qctrl_pkg::data_width-1:0] fproc_result,
	input wire qdrv_busy,
	input wire rdrv_busy,
	input wire rdlo_busy,
	output wire qdrv_stb,
	output wire [qctrl_pkg::qdrv_env_width-1:0] qdrv_env_start,
	output wire [qctrl_pkg::qdrv_env_width-1:0] qdrv_env_length,
	output wire [qctrl_pkg::amp_width-1:0] qdrv_amp,
	output wire [qctrl_pkg::freq_width-1:0] qdrv_freq,
	output wire [qctrl_pkg::phase_width-1:0] qdrv_phase,
	output wire [qctrl_pkg::mode_width-1:0] qdrv_mode,
	output wire rdrv_stb,
	output wire [qctrl_pkg::rd_env_width-1:0] rdrv_env_start,
	output wire [qctrl_pkg::rd_env_width-1:0] rdrv_env_length,
	output wire [qctrl_pkg::amp_width-1:0] rdrv_amp,
	output wire [qctrl_pkg::freq_width-1:0] rdrv_freq,
	output wire [qctrl_pkg::phase_width-1:0] rdrv_phase,
	output wire [qctrl_pkg::mode_width-1:0] rdrv_mode,
	output wire rdlo_stb,
	output wire [qctrl_pkg::rd_env_width-1:0] rdlo_env_start,
	output wire [qctrl_pkg::rd_env_width-1:0] rdlo_env_length,
	output wire [qctrl_pkg::amp_width-1:0] rdlo_amp,
	output wire [qctrl_pkg::freq_width-1:0] rdlo_freq,
	output wire [qctrl_pkg::phase_width-1:0] rdlo_phase,
	output wire [qctrl_pkg::mode_width-1:0] rdlo_mode,
	output wire idle,
	output wire done
);
	import qctrl_pkg::*;

	// control to pulse registers.
	logic pulse_load;
	logic pulse_trig;

	// pulse registers to dispatch.
	logic cstrobe;
	logic [env_width-1:0] env_word;
	logic [phase_width-1:0] phase;
	logic [freq_width-1:0] freq;
	logic [amp_width-1:0] amp;
	logic [cfg_width-1:0] cfg;

	proc_ctrl #(
		.cmd_addr_width(cmd_addr_width),
		.cmd_mem_read_latency(cmd_mem_read_latency)
	) ctrl (.*);

	pulse_regs pregs (.*);

	elem_dispatch dispatch (.*); // per-element strobes and idle.

endmodule

`default_nettype wire

/* src/elem_dispatch.sv */
`timescale 1ns/10ps
`default_nettype none

module elem_dispatch (
	input wire clk,
	input wire arst_n,
	input wire cstrobe,
	input wire [qctrl_pkg::env_width-1:0] env_word,
	input wire [qctrl_pkg::phase_width-1:0] phase,
	input wire [qctrl_pkg::freq_width-1:0] freq,
	input wire [qctrl_pkg::amp_width-1:0] amp,
	input wire [qctrl_pkg::cfg_width-1:0] cfg,
	input wire qdrv_busy,
	input wire rdrv_busy,
	input wire rdlo_busy,
	output logic qdrv_stb,
	output logic [qctrl_pkg::qdrv_env_width-1:0] qdrv_env_start,
	output logic [qctrl_pkg::qdrv_env_width-1:0] qdrv_env_length,
	output logic [qctrl_pkg::amp_width-1:0] qdrv_amp,
	output logic [qctrl_pkg::freq_width-1:0] qdrv_freq,
	output logic [qctrl_pkg::phase_width-1:0] qdrv_phase,
	output logic [qctrl_pkg::mode_width-1:0] qdrv_mode,
	output logic rdrv_stb,
	output logic [qctrl_pkg::rd_env_width-1:0] rdrv_env_start,
	output logic [qctrl_pkg::rd_env_width-1:0] rdrv_env_length,
	output logic [qctrl_pkg::amp_width-1:0] rdrv_amp,
	output logic [qctrl_pkg::freq_width-1:0] rdrv_freq,
	output logic [qctrl_pkg::phase_width-1:0] rdrv_phase,
	output logic [qctrl_pkg::mode_width-1:0] rdrv_mode,
	output logic rdlo_stb,
	output logic [qctrl_pkg::rd_env_width-1:0] rdlo_env_start,
	output logic [qctrl_pkg::rd_env_width-1:0] rdlo_env_length,
	output logic [qctrl_pkg::amp_width-1:0] rdlo_amp,
	output logic [qctrl_pkg::freq_width-1:0] rdlo_freq,
	output logic [qctrl_pkg::phase_width-1:0] rdlo_phase,
	output logic [qctrl_pkg::mode_width-1:0] rdlo_mode,
	output logic idle
);
	import qctrl_pkg::*;

	elem_t sel;
	logic qdrv_hit, rdrv_hit, rdlo_hit;

	assign sel = elem_t'(cfg[1:0]);
	assign qdrv_hit = cstrobe && (sel == elem_qdrv);
	assign rdrv_hit = cstrobe && (sel == elem_rdrv);
	assign rdlo_hit = cstrobe && (sel == elem_rdlo); // elem_none hits nothing.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			qdrv_stb <= 1'b0;
			rdrv_stb <= 1'b0;
			rdlo_stb <= 1'b0;
			idle <= 1'b1;
		end else begin
			qdrv_stb <= qdrv_hit;
			rdrv_stb <= rdrv_hit;
			rdlo_stb <= rdlo_hit;
			idle <= ~|{qdrv_busy, rdrv_busy, rdlo_busy};
		end
	end

	// channel fields, only the selected element is updated.
	always_ff @(posedge clk) begin
		if (qdrv_hit) begin
			qdrv_env_start <= env_word[qdrv_env_width-1:0];
			qdrv_env_length <= env_word[env_len_lsb+qdrv_env_width-1:env_len_lsb];
			qdrv_amp <= amp;
			qdrv_freq <= freq;
			qdrv_phase <= phase;
			qdrv_mode <= cfg[3:2];
		end
		if (rdrv_hit) begin
			rdrv_env_start <= env_word[rd_env_width-1:0];
			rdrv_env_length <= env_word[env_len_lsb+rd_env_width-1:env_len_lsb];
			rdrv_amp <= amp;
			rdrv_freq <= freq;
			rdrv_phase <= phase;
			rdrv_mode <= cfg[3:2];
		end
		if (rdlo_hit) begin
			rdlo_env_start <= env_word[rd_env_width-1:0];
			rdlo_env_length <= env_word[env_len_lsb+rd_env_width-1:env_len_lsb];
			rdlo_amp <= amp;
			rdlo_freq <= freq;
			rdlo_phase <= phase;
			rdlo_mode <= cfg[3:2];
		end
	end

	assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0({qdrv_stb, rdrv_stb, rdlo_stb}));

endmodule

`default_nettype wire

/* src/pulse_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module pulse_regs (
	input wire clk,
	input wire arst_n,
	input wire [qctrl_pkg::cmd_width-1:0] command,
	input wire pulse_load,
	input wire pulse_trig,
	output logic cstrobe,
	output logic [qctrl_pkg::env_width-1:0] env_word,
	output logic [qctrl_pkg::phase_width-1:0] phase,
	output logic [qctrl_pkg::freq_width-1:0] freq,
	output logic [qctrl_pkg::amp_width-1:0] amp,
	output logic [qctrl_pkg::cfg_width-1:0] cfg
);
	import qctrl_pkg::*;

	// strobe one cycle after the trigger command executes.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cstrobe <= 1'b0;
		end else begin
			cstrobe <= pulse_trig;
		end
	end

	always_ff @(posedge clk) begin
		// both pulse commands carry cfg.
		if (pulse_load || pulse_trig) begin
			cfg <= command[cfg_msb:cfg_lsb];
		end
		// the rest only on a write, so a trigger reuses the stored set.
		if (pulse_load) begin
			env_word <= command[env_msb:env_lsb];
			phase <= command[phase_msb:phase_lsb];
			freq <= command[freq_msb:freq_lsb];
			amp <= command[amp_msb:amp_lsb];
		end
	end

endmodule

`default_nettype wire

/* src/proc_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module proc_ctrl #(
	parameter int cmd_addr_width = 16,
	parameter int cmd_mem_read_latency = 3
) (
	input wire clk,
	input wire arst_n,
	input wire [qctrl_pkg::cmd_width-1:0] command,
	input wire fproc_ack,
	input wire [qctrl_pkg::data_width-1:0] fproc_result,
	output logic [cmd_addr_width-1:0] cmd_read_addr,
	output logic pulse_load,
	output logic pulse_trig,
	output logic fproc_req,
	output logic [qctrl_pkg::fproc_id_width-1:0] fproc_id,
	output logic done
);
	import qctrl_pkg::*;

	localparam int cnt_width = $clog2(cmd_mem_read_latency + 1);

	ctrl_state_t state;
	opcode_t opcode;
	logic [cmd_addr_width-1:0] ip; // instruction pointer.
	logic [cmd_addr_width-1:0] target;
	logic [cnt_width-1:0] wait_cnt;
	logic [data_width-1:0] fproc_data;
	logic fproc_hs; // req and ack both high.
	logic exec;

	// command stays valid while cmd_read_addr is held.
	assign opcode = opcode_t'(command[op_msb:op_lsb]);
	assign target = cmd_addr_width'(command[jump_msb:jump_lsb]);
	assign exec = (state == st_exec);
	assign fproc_hs = (state == st_fproc_req) && fproc_req && fproc_ack;

	assign pulse_load = exec && (opcode == op_pulse_write);
	assign pulse_trig = exec && (opcode == op_pulse_trig);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_fetch;
			ip <= '0;
			cmd_read_addr <= '0;
			wait_cnt <= '0;
			fproc_req <= 1'b0;
			fproc_id <= '0;
			done <= 1'b0;
		end else begin
			case (state)
				st_fetch: begin
					cmd_read_addr <= ip;
					wait_cnt <= '0;
					state <= st_wait;
				end
				st_wait: begin
					// memory answers cmd_mem_read_latency cycles after the address.
					if (wait_cnt == cnt_width'(cmd_mem_read_latency - 1)) begin
						state <= st_exec;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				st_exec: begin
					state <= st_fetch;
					case (opcode)
						op_jump: ip <= target;
						op_jump_fproc: begin
							fproc_id <= command[fproc_id_msb:fproc_id_lsb];
							state <= st_fproc_req;
						end
						op_done: begin
							done <= 1'b1; // held until reset.
							state <= st_done;
						end
						default: ip <= ip + 1'b1; // nop, pulses and unknown opcodes.
					endcase
				end
				st_fproc_req: begin
					// a new request only once the previous ack is gone.
					if (!fproc_req && !fproc_ack) begin
						fproc_req <= 1'b1;
					end else if (fproc_hs) begin
						fproc_req <= 1'b0;
						state <= st_fproc_rel;
					end
				end
				st_fproc_rel: begin
					if (fproc_data == command[imm_msb:imm_lsb]) begin
						ip <= target; // branch taken.
					end else begin
						ip <= ip + 1'b1;
					end
					state <= st_fetch;
				end
				st_done: state <= st_done;
				default: state <= st_fetch;
			endcase
		end
	end

	// result captured on the handshake edge.
	always_ff @(posedge clk) begin
		if (fproc_hs) begin
			fproc_data <= fproc_result;
		end
	end

	// four-phase order: release only after the ack was seen.
	assert property (@(posedge clk) disable iff (!arst_n)
		$fell(fproc_req) |-> $past(fproc_ack));

	assert property (@(posedge clk) disable iff (!arst_n)
		!(pulse_load && pulse_trig));

endmodule

`default_nettype wire

/* src/qctrl_pkg.sv */
`default_nettype none

package qctrl_pkg;

	// field widths.
	localparam int env_width = 24;
	localparam int phase_width = 17;
	localparam int freq_width = 9;
	localparam int amp_width = 16;
	localparam int cfg_width = 4; // [1:0] element select, [3:2] mode.
	localparam int mode_width = 2;
	localparam int cmd_width = 128;
	localparam int data_width = 32;
	localparam int fproc_id_width = 8;

	// envelope slicing per element.
	localparam int qdrv_env_width = 10;
	localparam int rd_env_width = 12;
	localparam int env_len_lsb = 12;

	// command word layout.
	localparam int op_msb = 127;
	localparam int op_lsb = 124;
	localparam int cfg_msb = 123;
	localparam int cfg_lsb = 120;
	localparam int amp_msb = 119;
	localparam int amp_lsb = 104;
	localparam int freq_msb = 103;
	localparam int freq_lsb = 95;
	localparam int phase_msb = 94;
	localparam int phase_lsb = 78;
	localparam int env_msb = 77;
	localparam int env_lsb = 54;
	localparam int jump_msb = 63; // overlaps env, never in the same opcode.
	localparam int jump_lsb = 48;
	localparam int fproc_id_msb = 47;
	localparam int fproc_id_lsb = 40;
	localparam int imm_msb = 31;
	localparam int imm_lsb = 0;

	typedef enum logic [3:0] {
		op_nop = 4'd0,
		op_pulse_write = 4'd1,
		op_pulse_trig = 4'd2,
		op_jump = 4'd3,
		op_jump_fproc = 4'd4,
		op_done = 4'd5
	} opcode_t;

	typedef enum logic [2:0] {
		st_fetch,
		st_wait,
		st_exec,
		st_fproc_req,
		st_fproc_rel,
		st_done
	} ctrl_state_t;

	typedef enum logic [1:0] {
		elem_qdrv = 2'd0,
		elem_rdrv = 2'd1,
		elem_rdlo = 2'd2,
		elem_none = 2'd3
	} elem_t;

endpackage

`default_nettype wire
